// ==== vlog.f ====
hw/fetch_pkg.sv
hw/inst_mem.sv
hw/fetch_unit.sv
hw/commit_unit.sv
hw/fetch_top.sv
test/fetch_properties.sv
test/tb_fetch.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_fetch
FILELIST  := vlog.f
OBJDIR    := obj_dir
SIM_BIN   := $(OBJDIR)/V$(TOP)
LOG       := sim.log
# let assertion failures reach the end-of-test summary
SIM_ARGS  := +verilator+error+limit+1000
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^RESULT: PASS$$' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== test/tb_fetch.sv ====
// runs a random JAL-heavy program, then a short program that ends in a jump to itself
// PCs are compared in full, words through the word address modulo MEM_WORDS
`timescale 1ns/100ps
`default_nettype none

module tb_fetch;

  import fetch_pkg::*;

  localparam int MEM_WORDS    = 256;
  localparam int EXEC_CYCLES  = 2;
  localparam int IDX_W        = $clog2(MEM_WORDS);
  localparam int RESET_CYCLES = 10;
  localparam int N_RANDOM     = 500;
  localparam int N_LOOP       = 12;
  // two fetches at the longest memory latency, then execute
  localparam int MAX_CPI      = 2 * (4 + 3) + EXEC_CYCLES + 2;
  localparam int WATCHDOG_CYCLES = 2 * (N_RANDOM + N_LOOP) * MAX_CPI
                                 + 2 * 2 * (MEM_WORDS + RESET_CYCLES + 2);
  localparam logic [31:0] LFSR_SEED = 32'hfc76b8d3;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;
  localparam inst_t       INST_ADDI = 32'h0000_0013;

  logic             clk;
  logic             rst;
  logic             load_en;
  logic [IDX_W-1:0] load_addr;
  inst_t            load_data;
  logic             retire;
  addr_t            retire_pc;
  inst_t            retire_inst;

  // mirror of the memory contents
  inst_t       prog [MEM_WORDS];
  logic [31:0] lfsr_state;
  addr_t       exp_pc;
  int          n_retired;

  fetch_top #(
    .MEM_WORDS   (MEM_WORDS),
    .EXEC_CYCLES (EXEC_CYCLES)
  ) DUT (
    .clk           (clk),
    .rst           (rst),
    .i_load_en     (load_en),
    .i_load_addr   (load_addr),
    .i_load_data   (load_data),
    .o_retire      (retire),
    .o_retire_pc   (retire_pc),
    .o_retire_inst (retire_inst)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // one LFSR step per bit
  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // J-type encoding of a byte offset
  function automatic inst_t jal_word(input int offset, input logic [4:0] rd);
    logic [20:0] imm;
    imm = 21'(offset);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // first words straight-line, then about one JAL in four
  task automatic build_random_program();
    logic [31:0] sel;
    logic [31:0] k;
    logic [31:0] word;
    for (int i = 0; i < MEM_WORDS; i++) begin
      take_bits(2, sel);
      take_bits(32, word);
      if (i >= 4 && sel == 0) begin
        take_bits(3, k);
        case (k)
          0: prog[i] = jal_word(4, word[11:7]);
          // lands one word on, but a whole memory further in PC
          6: prog[i] = jal_word(MEM_WORDS * 4 + 4, word[11:7]);
          default: prog[i] = jal_word(4 * (int'(k) + 1), word[11:7]);
        endcase
      end else begin
        if (word[6:0] == OPC_JAL) begin
          word[2] = 1'b0;
        end
        prog[i] = word;
      end
    end
  endtask

  // 0, JAL +4, JAL +8, skipped word, JAL to itself
  task automatic build_loop_program();
    for (int i = 0; i < MEM_WORDS; i++) begin
      prog[i] = INST_ADDI;
    end
    prog[1] = jal_word(4, 5'd1);
    prog[2] = jal_word(8, 5'd1);
    prog[4] = jal_word(0, 5'd0);
  endtask

  // load under reset, release, wait for the retires, reset again
  task automatic run_phase(input int n_retires);
    int base;
    for (int i = 0; i < MEM_WORDS; i++) begin
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= IDX_W'(i);
      load_data <= prog[i];
    end
    @(posedge clk);
    load_en <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst  <= 1'b0;
    base = n_retired;
    while (n_retired < base + n_retires) begin
      @(posedge clk);
    end
    rst <= 1'b1;
    @(posedge clk);
  endtask

  ////////////////////////////////////////
  // reference model and compare
  ////////////////////////////////////////

  // JAL goes to PC plus its immediate, everything else to PC plus 4
  function automatic addr_t ref_next_pc(input addr_t pc, input inst_t inst);
    logic [20:0] imm;
    imm = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    if (inst[6:0] != OPC_JAL) begin
      return pc + 64'd4;
    end
    return pc + addr_t'($signed(imm));
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] want);
    if (got !== want) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, want);
      $display("RESULT: FAIL");
      $fatal(1, "retire mismatch");
    end
  endtask

  always @(posedge clk) begin : compare
    inst_t exp_inst;
    if (rst) begin
      exp_pc <= PC_START;
    end else if (retire) begin
      exp_inst = prog[exp_pc[IDX_W+1:2]];
      check_value("retire pc", retire_pc, exp_pc);
      check_value("retire word", 64'(retire_inst), 64'(exp_inst));
      exp_pc    <= ref_next_pc(exp_pc, exp_inst);
      n_retired <= n_retired + 1;
    end
  end

  // a failed bus or strobe assertion ends the run at once
  always @(posedge clk) begin : assertion_watch
    if (DUT.u_fetch_unit.u_fetch_props.fail_cnt != 0) begin
      $display("%0d bus or strobe assertions failed",
               DUT.u_fetch_unit.u_fetch_props.fail_cnt);
      $display("RESULT: FAIL");
      $fatal(1, "assertion failure");
    end
  end

  ////////////////////////////////////////
  // sequence and watchdog
  ////////////////////////////////////////

  initial begin : main
    rst        = 1'b1;
    load_en    = 1'b0;
    load_addr  = '0;
    load_data  = INST_NOP;
    lfsr_state = LFSR_SEED;
    exp_pc     = PC_START;
    n_retired  = 0;
    build_random_program();
    run_phase(N_RANDOM);
    build_loop_program();
    run_phase(N_LOOP);
    $display("%0d instructions retired and checked", n_retired);
    if (DUT.u_fetch_unit.u_fetch_props.fail_cnt == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("%0d bus or strobe assertions failed",
               DUT.u_fetch_unit.u_fetch_props.fail_cnt);
      $display("RESULT: FAIL");
      $fatal(1, "assertion failures");
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, retires stopped coming", WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// ==== test/fetch_properties.sv ====
// bus and strobe checks, bound into every fetch_unit
// checks are off while rst is high
`timescale 1ns/100ps
`default_nettype none

module fetch_properties (
  input wire logic             clk,
  input wire logic             rst,
  input wire logic             i_bus_req,
  input wire logic             i_bus_ack,
  input wire fetch_pkg::addr_t i_bus_addr,
  input wire logic             i_fetched
);

  // failed assertions so far
  int fail_cnt = 0;

  // address holds until the memory answers
  addr_stable: assert property (@(posedge clk) disable iff (rst)
    i_bus_req && !i_bus_ack |=> $stable(i_bus_addr))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("bus address changed while the request was waiting");
    end

  ack_has_req: assert property (@(posedge clk) disable iff (rst)
    i_bus_ack |-> i_bus_req)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("ack without a request");
    end

  fetched_pulse: assert property (@(posedge clk) disable iff (rst)
    i_fetched |=> !i_fetched)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("fetched strobe longer than one cycle");
    end

endmodule

bind fetch_unit fetch_properties u_fetch_props (
  .clk        (clk),
  .rst        (rst),
  .i_bus_req  (o_bus_req),
  .i_bus_ack  (i_bus_ack),
  .i_bus_addr (o_bus_addr),
  .i_fetched  (o_fetched)
);

`default_nettype wire

// ==== hw/fetch_top.sv ====
// fetch front end: memory, fetch unit and commit stage
// MEM_WORDS a power of two; program loaded while rst is high
`timescale 1ns/100ps
`default_nettype none

module fetch_top #(
  parameter int MEM_WORDS   = 256,
  parameter int EXEC_CYCLES = 2
) (
  input  wire logic                         clk,
  input  wire logic                         rst,

  input  wire logic                         i_load_en,
  input  wire logic [$clog2(MEM_WORDS)-1:0] i_load_addr,
  input  wire fetch_pkg::inst_t             i_load_data,

  output logic                              o_retire,
  output fetch_pkg::addr_t                  o_retire_pc,
  output fetch_pkg::inst_t                  o_retire_inst
);

  import fetch_pkg::*;

  // fetch bus
  logic  bus_req;
  logic  bus_ack;
  addr_t bus_addr;
  inst_t bus_rdata;

  // fetch to commit and back
  logic  fetched;
  addr_t fetch_pc;
  inst_t fetch_inst;
  logic  jmp;
  addr_t jmp_addr;
  logic  wb_done;

  inst_mem #(
    .MEM_WORDS (MEM_WORDS)
  ) u_inst_mem (
    .clk         (clk),
    .rst         (rst),
    .i_load_en   (i_load_en),
    .i_load_addr (i_load_addr),
    .i_load_data (i_load_data),
    .i_req       (bus_req),
    .i_addr      (bus_addr),
    .o_ack       (bus_ack),
    .o_rdata     (bus_rdata)
  );

  fetch_unit u_fetch_unit (
    .clk         (clk),
    .rst         (rst),
    .i_bus_ack   (bus_ack),
    .i_bus_rdata (bus_rdata),
    .o_bus_req   (bus_req),
    .o_bus_addr  (bus_addr),
    .i_wb_done   (wb_done),
    .i_jmp       (jmp),
    .i_jmp_addr  (jmp_addr),
    .o_pc        (fetch_pc),
    .o_inst      (fetch_inst),
    .o_fetched   (fetched)
  );

  commit_unit #(
    .EXEC_CYCLES (EXEC_CYCLES)
  ) u_commit_unit (
    .clk           (clk),
    .rst           (rst),
    .i_fetched     (fetched),
    .i_pc          (fetch_pc),
    .i_inst        (fetch_inst),
    .o_jmp         (jmp),
    .o_jmp_addr    (jmp_addr),
    .o_wb_done     (wb_done),
    .o_retire      (o_retire),
    .o_retire_pc   (o_retire_pc),
    .o_retire_inst (o_retire_inst)
  );

endmodule

`default_nettype wire

// ==== hw/commit_unit.sv ====
// decodes JAL only, every other word retires as a plain instruction
// EXEC_CYCLES must be at least 1
`timescale 1ns/100ps
`default_nettype none

module commit_unit #(
  parameter int EXEC_CYCLES = 2
) (
  input  wire logic             clk,
  input  wire logic             rst,

  // from fetch
  input  wire logic             i_fetched,
  input  wire fetch_pkg::addr_t i_pc,
  input  wire fetch_pkg::inst_t i_inst,

  // back to fetch
  output logic                  o_jmp,
  output fetch_pkg::addr_t      o_jmp_addr,
  output logic                  o_wb_done,

  // retire trace
  output logic                  o_retire,
  output fetch_pkg::addr_t      o_retire_pc,
  output fetch_pkg::inst_t      o_retire_inst
);

  import fetch_pkg::*;

  localparam int CNT_W = (EXEC_CYCLES > 1) ? $clog2(EXEC_CYCLES) : 1;

  typedef enum logic {
    ST_IDLE,
    ST_EXEC
  } state_t;

  state_t           state;
  logic [CNT_W-1:0] exec_cnt;
  logic             is_jal;
  addr_t            jal_imm;

  assign is_jal  = (i_inst[6:0] == OPC_JAL);
  // J-type immediate, imm[20|10:1|11|19:12]
  assign jal_imm = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                    i_inst[30:21], 1'b0};

  ////////////////////////////////////////
  // retire and jump report
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      o_retire <= 1'b0;
      o_jmp    <= 1'b0;
    end else begin
      o_retire <= i_fetched;
      o_jmp    <= i_fetched & is_jal;
    end
  end

  always_ff @(posedge clk) begin
    if (i_fetched) begin
      o_retire_pc   <= i_pc;
      o_retire_inst <= i_inst;
      o_jmp_addr    <= i_pc + jal_imm;
    end
  end

  ////////////////////////////////////////
  // execute delay
  ////////////////////////////////////////

  // counting starts with the retire cycle, so wb_done lands EXEC_CYCLES later
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_IDLE;
      exec_cnt  <= '0;
      o_wb_done <= 1'b0;
    end else begin
      o_wb_done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (i_fetched) begin
            state    <= ST_EXEC;
            exec_cnt <= CNT_W'(EXEC_CYCLES - 1);
          end
        end
        ST_EXEC: begin
          if (exec_cnt == '0) begin
            state     <= ST_IDLE;
            o_wb_done <= 1'b1;
          end else begin
            exec_cnt <= exec_cnt - 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/fetch_unit.sv ====
// predicts PC+4; a mispredicted jump costs one discarded fetch before the target
// assumes no new jump arrives while the bus request is high
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
  input  wire logic             clk,
  input  wire logic             rst,

  // fetch bus
  input  wire logic             i_bus_ack,
  input  wire fetch_pkg::inst_t i_bus_rdata,
  output logic                  o_bus_req,
  output fetch_pkg::addr_t      o_bus_addr,

  // commit side
  input  wire logic             i_wb_done,
  input  wire logic             i_jmp,
  input  wire fetch_pkg::addr_t i_jmp_addr,
  output fetch_pkg::addr_t      o_pc,
  output fetch_pkg::inst_t      o_inst,
  output logic                  o_fetched
);

  import fetch_pkg::*;

  logic  handshake;
  logic  mispredict;
  // word in flight is stale, fetch saved_target instead
  logic  refetch;
  addr_t saved_target;
  addr_t pc_pred;

  assign handshake  = o_bus_req & i_bus_ack;
  assign mispredict = i_jmp & (i_jmp_addr != pc_pred);

  ////////////////////////////////////////
  // bus request
  ////////////////////////////////////////

  // high out of reset so the first word is fetched without a write-back
  always_ff @(posedge clk) begin
    if (rst) begin
      o_bus_req <= 1'b1;
    end else if (handshake) begin
      // keep requesting when the returned word is to be dropped
      if (!refetch) begin
        o_bus_req <= 1'b0;
      end
    end else if (i_wb_done) begin
      o_bus_req <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // PC sequencing
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      refetch    <= 1'b0;
      o_bus_addr <= PC_START;
      pc_pred    <= PC_START;
      o_fetched  <= 1'b0;
      o_inst     <= INST_NOP;
    end else begin
      o_fetched <= 1'b0;
      o_inst    <= INST_NOP;
      if (mispredict) begin
        refetch <= 1'b1;
      end else if (handshake) begin
        if (refetch) begin
          // discard this word and go to the jump target
          refetch    <= 1'b0;
          o_bus_addr <= saved_target;
          pc_pred    <= saved_target + INST_BYTES;
        end else begin
          o_bus_addr <= o_bus_addr + INST_BYTES;
          pc_pred    <= o_bus_addr + INST_BYTES;
          o_fetched  <= 1'b1;
          o_inst     <= i_bus_rdata;
        end
      end
    end
  end

  // payload, only meaningful next to its strobe
  always_ff @(posedge clk) begin
    if (mispredict) begin
      saved_target <= i_jmp_addr;
    end
    if (handshake && !refetch) begin
      o_pc <= o_bus_addr;
    end
  end

endmodule

`default_nettype wire

// ==== hw/inst_mem.sv ====
// word memory, loadable only while rst is high; address taken modulo MEM_WORDS
// ack comes 1 + addr[3:2] cycles after a request is first seen
`timescale 1ns/100ps
`default_nettype none

module inst_mem #(
  parameter int MEM_WORDS = 256
) (
  input  wire logic                         clk,
  input  wire logic                         rst,

  // program load
  input  wire logic                         i_load_en,
  input  wire logic [$clog2(MEM_WORDS)-1:0] i_load_addr,
  input  wire fetch_pkg::inst_t             i_load_data,

  // fetch bus
  input  wire logic                         i_req,
  input  wire fetch_pkg::addr_t             i_addr,
  output logic                              o_ack,
  output fetch_pkg::inst_t                  o_rdata
);

  import fetch_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);

  inst_t            mem [MEM_WORDS];
  logic             busy;
  logic [1:0]       wait_cnt;
  logic [IDX_W-1:0] word_idx;

  // byte address to word index, upper bits wrap
  assign word_idx = i_addr[IDX_W+1:2];

  always_ff @(posedge clk) begin
    if (rst && i_load_en) begin
      mem[i_load_addr] <= i_load_data;
    end
  end

  ////////////////////////////////////////
  // latency counter
  ////////////////////////////////////////

  // a request still high in the ack cycle is not taken as new
  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      wait_cnt <= 2'd0;
      o_ack    <= 1'b0;
    end else begin
      o_ack <= 1'b0;
      if (busy) begin
        if (wait_cnt == 2'd0) begin
          busy  <= 1'b0;
          o_ack <= 1'b1;
        end else begin
          wait_cnt <= wait_cnt - 2'd1;
        end
      end else if (i_req && !o_ack) begin
        busy     <= 1'b1;
        wait_cnt <= i_addr[3:2];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (busy && wait_cnt == 2'd0) begin
      o_rdata <= mem[word_idx];
    end
  end

endmodule

`default_nettype wire

// ==== hw/fetch_pkg.sv ====
// shared types and constants for the fetch front end
// instructions are 32-bit words at 4-byte aligned addresses, PCs are 64-bit
`default_nettype none

package fetch_pkg;

  ////////////////////////////////////////
  // word types
  ////////////////////////////////////////

  // byte address or PC
  typedef logic [63:0] addr_t;

  // one instruction word
  typedef logic [31:0] inst_t;

  // major opcode field, inst[6:0]
  typedef logic [6:0] opcode_t;

  ////////////////////////////////////////
  // constants
  ////////////////////////////////////////

  // first fetch address after reset
  localparam addr_t PC_START = 64'h0;

  // bytes per instruction, the sequential PC step
  localparam addr_t INST_BYTES = 64'd4;

  // JAL, the only opcode the commit stage decodes
  localparam opcode_t OPC_JAL = 7'b1101111;

  // fetch output when no word is being handed over
  localparam inst_t INST_NOP = 32'h0000_0000;

endpackage

`default_nettype wire
